/* Makefile */
SIM := obj_dir/Vmatmul_tb

.PHONY: all run clean

all: run

$(SIM): matmul_top.f include/matmul_cfg.svh $(wildcard hdl/*.sv) sim/matmul_tb.sv
	verilator --binary --timing --assert -Wno-fatal --top-module matmul_tb -f matmul_top.f

run: $(SIM)
	@out=$$(./$(SIM)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf obj_dir

/* hdl/matmul_pkg.sv */
`include "matmul_cfg.svh"

package matmul_pkg;

  typedef logic [`MM_DWIDTH-1:0] elem_t;
  typedef logic [`MM_ACC_WIDTH-1:0] acc_t;

  // lane 0 in the low bits
  typedef logic [`MM_LANES*`MM_DWIDTH-1:0] row_t;
  typedef logic [`MM_AWIDTH-1:0] row_addr_t;

  // C[i][j] at element 4i+j
  typedef logic [`MM_LANES*`MM_LANES*`MM_DWIDTH-1:0] result_mat_t;

  typedef enum logic [1:0] {
    fd_idle,
    fd_feed,
    fd_drain,
    fd_wait_store
  } feed_state_t;

  typedef enum logic {
    st_idle,
    st_store
  } store_state_t;

endpackage

/* hdl/matmul_top.sv */
`timescale 1ns/100ps

module matmul_top import matmul_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      a_we,
  input  logic      b_we,
  input  row_addr_t wr_addr,
  input  row_t      wr_data,
  input  logic      start,
  input  row_addr_t rd_addr,
  output logic      busy,
  output logic      done,
  output row_t      rd_data
);

  row_addr_t feed_addr;
  row_t a_row;
  row_t b_row;
  row_t a_lanes;
  row_t b_lanes;
  logic clear;
  logic result_valid;
  result_mat_t results;
  logic c_we;
  row_addr_t c_addr;
  row_t c_data;

  // A holds columns, B holds rows
  row_ram mem_a (
    .clk     (clk),
    .we      (a_we),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (feed_addr),
    .rd_data (a_row)
  );

  row_ram mem_b (
    .clk     (clk),
    .we      (b_we),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (feed_addr),
    .rd_data (b_row)
  );

  operand_feeder u_feeder (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .done         (done),
    .a_row        (a_row),
    .b_row        (b_row),
    .rd_addr      (feed_addr),
    .a_lanes      (a_lanes),
    .b_lanes      (b_lanes),
    .clear        (clear),
    .result_valid (result_valid),
    .busy         (busy)
  );

  pe_array u_array (
    .clk     (clk),
    .reset   (reset),
    .clear   (clear),
    .a_lanes (a_lanes),
    .b_lanes (b_lanes),
    .results (results)
  );

  result_collector u_collector (
    .clk          (clk),
    .reset        (reset),
    .result_valid (result_valid),
    .results      (results),
    .c_we         (c_we),
    .c_addr       (c_addr),
    .c_data       (c_data),
    .done         (done)
  );

  // written by the collector, read back by the host
  row_ram mem_c (
    .clk     (clk),
    .we      (c_we),
    .wr_addr (c_addr),
    .wr_data (c_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

/* hdl/operand_feeder.sv */
`timescale 1ns/100ps
`include "matmul_cfg.svh"

module operand_feeder import matmul_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      start,
  input  logic      done,
  input  row_t      a_row,
  input  row_t      b_row,
  output row_addr_t rd_addr,
  output row_t      a_lanes,
  output row_t      b_lanes,
  output logic      clear,
  output logic      result_valid,
  output logic      busy
);

  localparam int DW = `MM_DWIDTH;
  localparam int STEP_W = $clog2(`MM_RESULT_STEP + 1);

  feed_state_t state;
  logic [STEP_W-1:0] step;
  logic word_valid;
  logic launch;

  // busy drops on the edge done rises, so a run can follow at once
  assign busy = (state != fd_idle) && !done;
  assign launch = start && !busy;

  // step 1 reads word 0
  assign rd_addr = row_addr_t'(step - 1'b1);
  assign result_valid = (state == fd_drain) && (step == STEP_W'(`MM_RESULT_STEP));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= fd_idle;
      step <= '0;
      clear <= 1'b0;
      word_valid <= 1'b0;
    end else begin
      clear <= launch;
      // memory answers one cycle after each address
      word_valid <= (state == fd_feed);
      if (launch) begin
        state <= fd_feed;
        step <= STEP_W'(1);
      end else begin
        case (state)
          fd_feed: begin
            step <= step + 1'b1;
            if (step == STEP_W'(`MM_LANES)) begin
              state <= fd_drain;
            end
          end
          fd_drain: begin
            step <= step + 1'b1;
            if (result_valid) begin
              state <= fd_wait_store;
            end
          end
          fd_wait_store: begin
            if (done) begin
              state <= fd_idle;
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  // triangular skew, lane i late by i cycles
  for (genvar i = 0; i < `MM_LANES; i++) begin : g_skew
    elem_t a_in;
    elem_t b_in;

    // zero outside the feed window
    assign a_in = word_valid ? a_row[i*DW +: DW] : '0;
    assign b_in = word_valid ? b_row[i*DW +: DW] : '0;

    if (i == 0) begin : g_direct
      assign a_lanes[i*DW +: DW] = a_in;
      assign b_lanes[i*DW +: DW] = b_in;
    end else begin : g_delay
      elem_t a_dly [i];
      elem_t b_dly [i];

      always_ff @(posedge clk) begin
        if (reset || clear) begin
          for (int s = 0; s < i; s++) begin
            a_dly[s] <= '0;
            b_dly[s] <= '0;
          end
        end else begin
          a_dly[0] <= a_in;
          b_dly[0] <= b_in;
          for (int s = 1; s < i; s++) begin
            a_dly[s] <= a_dly[s-1];
            b_dly[s] <= b_dly[s-1];
          end
        end
      end

      assign a_lanes[i*DW +: DW] = a_dly[i-1];
      assign b_lanes[i*DW +: DW] = b_dly[i-1];
    end
  end

endmodule

/* hdl/pe_array.sv */
`timescale 1ns/100ps
`include "matmul_cfg.svh"

module pe_array import matmul_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        clear,
  input  row_t        a_lanes,
  input  row_t        b_lanes,
  output result_mat_t results
);

  localparam int N = `MM_LANES;
  localparam int DW = `MM_DWIDTH;
  localparam int ACC_W = `MM_ACC_WIDTH;

  // a moves right, b moves down
  elem_t a_pass [N][N];
  elem_t b_pass [N][N];
  acc_t acc [N][N];

  for (genvar i = 0; i < N; i++) begin : g_row
    for (genvar j = 0; j < N; j++) begin : g_col
      elem_t a_in;
      elem_t b_in;

      // left column takes lane i of a
      if (j == 0) begin : g_a_edge
        assign a_in = a_lanes[i*DW +: DW];
      end else begin : g_a_inner
        assign a_in = a_pass[i][j-1];
      end

      // top row takes lane j of b
      if (i == 0) begin : g_b_edge
        assign b_in = b_lanes[j*DW +: DW];
      end else begin : g_b_inner
        assign b_in = b_pass[i-1][j];
      end

      // sum wraps mod 2^32
      always_ff @(posedge clk) begin
        if (reset || clear) begin
          a_pass[i][j] <= '0;
          b_pass[i][j] <= '0;
          acc[i][j] <= '0;
        end else begin
          a_pass[i][j] <= a_in;
          b_pass[i][j] <= b_in;
          acc[i][j] <= acc[i][j] + acc_t'(a_in) * acc_t'(b_in);
        end
      end

      // saturate when any upper bit is set
      assign results[(i*N+j)*DW +: DW] = (|acc[i][j][ACC_W-1:DW]) ?
                                         {DW{1'b1}} : acc[i][j][DW-1:0];
    end
  end

endmodule

/* hdl/result_collector.sv */
`timescale 1ns/100ps
`include "matmul_cfg.svh"

module result_collector import matmul_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        result_valid,
  input  result_mat_t results,
  output logic        c_we,
  output row_addr_t   c_addr,
  output row_t        c_data,
  output logic        done
);

  localparam int ROW_W = `MM_LANES * `MM_DWIDTH;

  store_state_t state;
  row_addr_t row;
  result_mat_t hold;
  logic last_wr;

  // snapshot of the array, rows go out from here
  always_ff @(posedge clk) begin
    if (result_valid) begin
      hold <= results;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      row <= '0;
      last_wr <= 1'b0;
      done <= 1'b0;
    end else begin
      // done one cycle after the last row is written
      last_wr <= c_we && (row == row_addr_t'(`MM_LANES - 1));
      done <= last_wr;
      case (state)
        st_idle: begin
          if (result_valid) begin
            state <= st_store;
            row <= '0;
          end
        end
        st_store: begin
          row <= row + 1'b1;
          if (row == row_addr_t'(`MM_LANES - 1)) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // one row of C per cycle
  assign c_we = (state == st_store);
  assign c_addr = row;
  assign c_data = hold[row*ROW_W +: ROW_W];

endmodule

/* hdl/row_ram.sv */
`timescale 1ns/100ps
`include "matmul_cfg.svh"

module row_ram import matmul_pkg::*; (
  input  logic      clk,
  input  logic      we,
  input  row_addr_t wr_addr,
  input  row_t      wr_data,
  input  row_addr_t rd_addr,
  output row_t      rd_data
);

  // one word per matrix row or column
  row_t mem [`MM_LANES];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, old data on a same-address write
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* include/matmul_cfg.svh */
`ifndef MATMUL_CFG_SVH
`define MATMUL_CFG_SVH

// element and accumulator widths
`define MM_DWIDTH 16
`define MM_ACC_WIDTH 32

// matrix order and row address width
`define MM_LANES 4
`define MM_AWIDTH 2

// edges from start until the last term has landed in every cell
`define MM_RESULT_STEP 12

`endif

/* matmul_top.f */
+incdir+include
hdl/matmul_pkg.sv
hdl/row_ram.sv
hdl/operand_feeder.sv
hdl/pe_array.sv
hdl/result_collector.sv
hdl/matmul_top.sv
sim/matmul_tb.sv

/* sim/matmul_tb.sv */
`timescale 1ns/100ps
`include "matmul_cfg.svh"

module matmul_tb import matmul_pkg::*; ();

  localparam int N = `MM_LANES;
  localparam int DW = `MM_DWIDTH;
  localparam int RUN_TIMEOUT = 40;
  localparam int QUIET_WINDOW = 30;

  logic clk;
  logic reset;
  logic a_we;
  logic b_we;
  row_addr_t wr_addr;
  row_t wr_data;
  logic start;
  row_addr_t rd_addr;
  logic busy;
  logic done;
  row_t rd_data;

  // host-side copies of the operand words
  row_t a_words [N];
  row_t b_words [N];
  logic [15:0] lfsr_state;
  int errors;
  int tests_run;
  int tests_failed;
  int done_count;
  int edges_since_start;

  matmul_top uut (
    .clk     (clk),
    .reset   (reset),
    .a_we    (a_we),
    .b_we    (b_we),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .start   (start),
    .rd_addr (rd_addr),
    .busy    (busy),
    .done    (done),
    .rd_data (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // edges since the last accepted start, and done pulses seen
  always @(posedge clk) begin
    if (reset) begin
      edges_since_start <= 0;
      done_count <= 0;
    end else begin
      if (start && !busy) begin
        edges_since_start <= 0;
      end else begin
        edges_since_start <= edges_since_start + 1;
      end
      if (done) begin
        done_count <= done_count + 1;
      end
    end
  end

  done_one_cycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else begin
      $display("done stayed high for more than one cycle at %0t ns", $time);
      errors++;
    end

  done_latency: assert property (@(posedge clk) disable iff (reset)
                                 done |-> edges_since_start == 17)
    else begin
      $display("Error at %0t ns: edges from start to done expected 17 actual %0d",
               $time, edges_since_start);
      errors++;
    end

  // busy drops on the same edge that raises done
  busy_low_on_done: assert property (@(posedge clk) disable iff (reset)
                                     done |-> !busy && $past(busy))
    else begin
      $display("busy did not fall on the edge where done rose, at %0t ns", $time);
      errors++;
    end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [15:0] val);
    val = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[14:0], lfsr_state[0]};
    end
  endtask

  // A word k carries column k, B word k carries row k
  task automatic set_a(input int i, input int k, input logic [15:0] v);
    a_words[k][i*DW +: DW] = v;
  endtask

  task automatic set_b(input int k, input int j, input logic [15:0] v);
    b_words[k][j*DW +: DW] = v;
  endtask

  task automatic fill_random(input int bits);
    logic [15:0] v;
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < N; c++) begin
        take_bits(bits, v);
        set_a(r, c, v);
        take_bits(bits, v);
        set_b(r, c, v);
      end
    end
  endtask

  // big rows of A and big columns of B, the rest small
  task automatic fill_full_range();
    logic [15:0] v;
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < N; c++) begin
        take_bits(4, v);
        set_a(r, c, (r < 2) ? (16'hFFF0 | v) : v);
        take_bits(4, v);
        set_b(r, c, (c < 2) ? (16'hFFF0 | v) : v);
      end
    end
  endtask

  function automatic row_t expected_c_row(input int i);
    row_t row;
    logic [31:0] sum;
    row = '0;
    for (int j = 0; j < N; j++) begin
      sum = '0;
      for (int k = 0; k < N; k++) begin
        sum = sum + 32'(a_words[k][i*DW +: DW]) * 32'(b_words[k][j*DW +: DW]);
      end
      row[j*DW +: DW] = (sum > 32'd65535) ? 16'hFFFF : sum[15:0];
    end
    return row;
  endfunction

  // A words first, then B words
  task automatic load_operands();
    for (int w = 0; w < 2 * N; w++) begin
      @(posedge clk);
      a_we <= (w < N);
      b_we <= (w >= N);
      wr_addr <= row_addr_t'(w % N);
      wr_data <= (w < N) ? a_words[w % N] : b_words[w % N];
    end
    @(posedge clk);
    a_we <= 1'b0;
    b_we <= 1'b0;
  endtask

  task automatic run_matmul(input int extra_start_at, output int cycles);
    logic seen;
    seen = 1'b0;
    cycles = 0;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    while (!seen && cycles < RUN_TIMEOUT) begin
      @(posedge clk);
      cycles++;
      start <= (cycles == extra_start_at);
      @(negedge clk);
      seen = done;
    end
    if (!seen) begin
      $display("no done pulse within %0d cycles of start, at %0t ns", RUN_TIMEOUT, $time);
      errors++;
    end
  endtask

  task automatic check_c();
    row_t expected;
    for (int i = 0; i < N; i++) begin
      @(posedge clk);
      rd_addr <= row_addr_t'(i);
      @(posedge clk);
      @(negedge clk);
      expected = expected_c_row(i);
      assert (rd_data === expected)
      else begin
        $display("Error at %0t ns: rd_data word %0d expected %h actual %h",
                 $time, i, expected, rd_data);
        errors++;
      end
    end
  endtask

  task automatic check_idle(input int n);
    for (int c = 0; c < n; c++) begin
      @(negedge clk);
      assert (busy === 1'b0)
      else begin
        $display("Error at %0t ns: busy expected 0 actual %b", $time, busy);
        errors++;
      end
      assert (done === 1'b0)
      else begin
        $display("Error at %0t ns: done expected 0 actual %b", $time, done);
        errors++;
      end
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
    end
  endtask

  initial begin
    int cycles;
    int errors_before;
    int dones_before;
    reset = 1'b1;
    start = 1'b0;
    a_we = 1'b0;
    b_we = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    rd_addr = '0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    lfsr_state = 16'd18;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    errors_before = errors;
    check_idle(20);
    finish_test("idle after reset", errors_before);

    // identity A passes B straight through
    errors_before = errors;
    fill_random(16);
    for (int i = 0; i < N; i++) begin
      for (int k = 0; k < N; k++) begin
        set_a(i, k, (i == k) ? 16'd1 : 16'd0);
      end
    end
    load_operands();
    run_matmul(0, cycles);
    assert (cycles == 17)
    else begin
      $display("Error at %0t ns: done latency expected 17 actual %0d", $time, cycles);
      errors++;
    end
    check_c();
    finish_test("identity", errors_before);

    errors_before = errors;
    fill_random(8);
    load_operands();
    run_matmul(0, cycles);
    check_c();
    finish_test("random 8-bit", errors_before);

    errors_before = errors;
    fill_full_range();
    load_operands();
    run_matmul(0, cycles);
    check_c();
    finish_test("full range", errors_before);

    // a start while busy must not begin a second run
    errors_before = errors;
    fill_random(8);
    load_operands();
    dones_before = done_count;
    run_matmul(5, cycles);
    check_idle(QUIET_WINDOW);
    assert (done_count - dones_before == 1)
    else begin
      $display("Error at %0t ns: done pulses expected 1 actual %0d",
               $time, done_count - dones_before);
      errors++;
    end
    check_c();
    finish_test("start while busy", errors_before);

    // second result must not carry the first run's sums
    // small second operands keep every sum below saturation
    errors_before = errors;
    fill_random(8);
    load_operands();
    run_matmul(0, cycles);
    fill_random(6);
    load_operands();
    run_matmul(0, cycles);
    check_c();
    finish_test("back to back", errors_before);

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
